/* logic/bch_bit_sequencer.sv */
`timescale 1ns/1ps

`include "bch_config.svh"

module bch_bit_sequencer (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  bch_pkg::bch_op_t   op,
	input  logic [`BCH_N-1:0]  word,
	output logic               busy,
	output logic               bit_out,
	output logic               bit_valid,
	output logic               feed,
	output logic               bit_last
);

	import bch_pkg::*;

	localparam logic [3:0] LAST_IDX = 4'(`BCH_N - 1);
	localparam logic [3:0] MSG_LAST = 4'(`BCH_K - 1);
	// Divider and collector stages still in flight after the last bit.
	localparam logic [1:0] DRAIN = 2'd2;

	seq_state_t state;
	logic [3:0] cnt;
	logic [`BCH_N-1:0] shreg;
	logic [1:0] tail;

	assign bit_out   = shreg[`BCH_N-1];
	assign bit_valid = (state != SEQ_IDLE);
	assign feed      = (state == SEQ_FEED);
	assign bit_last  = bit_valid && (cnt == LAST_IDX);
	assign busy      = bit_valid || (tail != 2'd0);

	// **************************************************
	// State machine and bit counter
	// **************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
			cnt   <= '0;
			tail  <= '0;
		end else begin
			if (tail != 2'd0) begin
				tail <= tail - 2'd1;
			end
			case (state)
				SEQ_IDLE: begin
					cnt <= '0;
					if (start) begin
						state <= SEQ_FEED;
					end
				end
				SEQ_FEED: begin
					cnt <= cnt + 4'd1;
					if (cnt == LAST_IDX) begin
						state <= SEQ_IDLE;
						tail  <= DRAIN;
					end else if (op == OP_ENCODE && cnt == MSG_LAST) begin
						// Message done, parity drains next.
						state <= SEQ_FLUSH;
					end
				end
				SEQ_FLUSH: begin
					cnt <= cnt + 4'd1;
					if (cnt == LAST_IDX) begin
						state <= SEQ_IDLE;
						tail  <= DRAIN;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	// MSB first shift register.
	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE) begin
			if (op == OP_ENCODE) begin
				shreg <= {word[`BCH_K-1:0], {`BCH_P{1'b0}}};
			end else begin
				shreg <= word;
			end
		end else begin
			shreg <= {shreg[`BCH_N-2:0], 1'b0};
		end
	end

	// Encode ends in the flush phase, check in the feed phase.
	a_last_phase: assert property (
		@(posedge clk) disable iff (reset)
		bit_last |-> (feed == (op == OP_CHECK))
	);

	// Run ends in idle right after the last bit.
	a_idle_after_last: assert property (
		@(posedge clk) disable iff (reset)
		bit_last |=> !bit_valid
	);

endmodule

/* logic/bch_codec_top.sv */
`timescale 1ns/1ps

`include "bch_config.svh"

module bch_codec_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [15:0] wb_wdata,
	output logic [15:0] wb_rdata,
	output logic        wb_ack
);

	import bch_pkg::*;

	// Register file to sequencer.
	logic start;
	bch_op_t op;
	logic [`BCH_N-1:0] word;
	logic busy;

	// Sequencer to divider.
	logic bit_out;
	logic bit_valid;
	logic feed;
	logic bit_last;

	// Divider to collector.
	logic code_bit;
	logic code_valid;
	logic code_last;
	logic remainder_zero;

	// Collector back to registers.
	logic [`BCH_N-1:0] codeword;
	logic done;
	logic valid;

	bch_wb_regs u_regs (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_wdata(wb_wdata),
		.wb_rdata(wb_rdata), .wb_ack(wb_ack),
		.start(start), .op(op), .word(word),
		.busy(busy), .done(done), .valid(valid), .codeword(codeword)
	);

	bch_bit_sequencer u_seq (
		.clk(clk), .reset(reset),
		.start(start), .op(op), .word(word), .busy(busy),
		.bit_out(bit_out), .bit_valid(bit_valid),
		.feed(feed), .bit_last(bit_last)
	);

	bch_lfsr_divider u_div (
		.clk(clk), .reset(reset),
		.bit_in(bit_out), .bit_valid(bit_valid),
		.feed(feed), .bit_last(bit_last),
		.code_bit(code_bit), .code_valid(code_valid),
		.code_last(code_last), .remainder_zero(remainder_zero)
	);

	bch_word_collector u_coll (
		.clk(clk), .reset(reset), .start(start),
		.code_bit(code_bit), .code_valid(code_valid),
		.code_last(code_last), .remainder_zero(remainder_zero),
		.codeword(codeword), .done(done), .valid(valid)
	);

endmodule

/* logic/bch_config.svh */
`ifndef BCH_CONFIG_SVH
`define BCH_CONFIG_SVH

// **************************************************
// BCH(15,5) code sizes
// **************************************************

// Codeword length in bits.
`define BCH_N 15
// Message length in bits.
`define BCH_K 5
// Parity length, N - K.
`define BCH_P 10

// Generator 0x537 without its leading x^10 term.
`define BCH_GEN 10'h137

// **************************************************
// Register map
// **************************************************
`define BCH_ADDR_CTRL   2'd0
`define BCH_ADDR_DATA   2'd1
`define BCH_ADDR_STATUS 2'd2
`define BCH_ADDR_CODE   2'd3

`endif

/* logic/bch_lfsr_divider.sv */
`timescale 1ns/1ps

`include "bch_config.svh"

module bch_lfsr_divider (
	input  logic clk,
	input  logic reset,
	input  logic bit_in,
	input  logic bit_valid,
	input  logic feed,
	input  logic bit_last,
	output logic code_bit,
	output logic code_valid,
	output logic code_last,
	output logic remainder_zero
);

	localparam logic [`BCH_P-1:0] GEN = `BCH_GEN;

	logic [`BCH_P-1:0] lfsr;
	logic [`BCH_P-1:0] lfsr_cur;
	logic run;
	logic fb;

	// First bit of a run sees a cleared LFSR.
	assign lfsr_cur = (bit_valid && !run) ? '0 : lfsr;

	// Input XOR with the top LFSR bit.
	assign fb = bit_in ^ lfsr_cur[`BCH_P-1];

	assign remainder_zero = (lfsr == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
		end else if (bit_valid) begin
			run <= !bit_last;
		end
	end

	// **************************************************
	// Division register
	// **************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			lfsr <= '0;
		end else if (bit_valid) begin
			if (feed) begin
				lfsr <= {lfsr_cur[`BCH_P-2:0], 1'b0} ^ ({`BCH_P{fb}} & GEN);
			end else begin
				// Flush, plain shift.
				lfsr <= {lfsr_cur[`BCH_P-2:0], 1'b0};
			end
		end
	end

	// Message passes through, parity comes off the top.
	always_ff @(posedge clk) begin
		if (bit_valid) begin
			code_bit <= feed ? bit_in : lfsr_cur[`BCH_P-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			code_valid <= 1'b0;
			code_last  <= 1'b0;
		end else begin
			code_valid <= bit_valid;
			code_last  <= bit_last;
		end
	end

	a_code_last_valid: assert property (
		@(posedge clk) disable iff (reset)
		code_last |-> code_valid
	);

endmodule

/* logic/bch_pkg.sv */
package bch_pkg;

	// Operation selected by CTRL bit 1.
	typedef enum logic {
		OP_ENCODE = 1'b0,
		OP_CHECK  = 1'b1
	} bch_op_t;

	// Bit sequencer states.
	// Feed carries input bits, flush drains parity.
	typedef enum logic [1:0] {
		SEQ_IDLE  = 2'd0,
		SEQ_FEED  = 2'd1,
		SEQ_FLUSH = 2'd2
	} seq_state_t;

endpackage

/* logic/bch_wb_regs.sv */
`timescale 1ns/1ps

`include "bch_config.svh"

module bch_wb_regs (
	input  logic               clk,
	input  logic               reset,
	// Wishbone classic slave.
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  logic [1:0]         wb_adr,
	input  logic [15:0]        wb_wdata,
	output logic [15:0]        wb_rdata,
	output logic               wb_ack,
	// Codec control.
	output logic               start,
	output bch_pkg::bch_op_t   op,
	output logic [`BCH_N-1:0]  word,
	input  logic               busy,
	input  logic               done,
	input  logic               valid,
	input  logic [`BCH_N-1:0]  codeword
);

	import bch_pkg::*;

	logic req;
	logic wr_req;
	logic locked;
	logic ctrl_go;

	// New request only when no ack is pending.
	assign req    = wb_cyc && wb_stb && !wb_ack;
	assign wr_req = req && wb_we;

	// Start pulse counts too, busy rises a cycle later.
	assign locked = busy || start;

	assign ctrl_go = wr_req && (wb_adr == `BCH_ADDR_CTRL) && wb_wdata[0] && !locked;

	// **************************************************
	// Bus handshake
	// **************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;
		end
	end

	// **************************************************
	// Control and data registers
	// **************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
			op    <= OP_ENCODE;
		end else begin
			start <= ctrl_go;
			// Operation latched together with the start.
			if (ctrl_go) begin
				op <= bch_op_t'(wb_wdata[1]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			word <= '0;
		end else if (wr_req && (wb_adr == `BCH_ADDR_DATA) && !locked) begin
			word <= wb_wdata[`BCH_N-1:0];
		end
	end

	// **************************************************
	// Read mux
	// **************************************************
	// Address is held by the host until ack.
	always_comb begin
		case (wb_adr)
			`BCH_ADDR_DATA: begin
				wb_rdata = {1'b0, word};
			end
			`BCH_ADDR_STATUS: begin
				wb_rdata = {13'b0, valid, done, busy};
			end
			`BCH_ADDR_CODE: begin
				wb_rdata = {1'b0, codeword};
			end
			default: begin
				// CTRL is write only.
				wb_rdata = '0;
			end
		endcase
	end

	// Single-cycle ack per transfer.
	a_ack_single: assert property (
		@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack
	);

endmodule

/* logic/bch_word_collector.sv */
`timescale 1ns/1ps

`include "bch_config.svh"

module bch_word_collector (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  logic               code_bit,
	input  logic               code_valid,
	input  logic               code_last,
	input  logic               remainder_zero,
	output logic [`BCH_N-1:0]  codeword,
	output logic               done,
	output logic               valid
);

	// **************************************************
	// Codeword assembly
	// **************************************************
	// Bits arrive MSB first.
	always_ff @(posedge clk) begin
		if (reset) begin
			codeword <= '0;
		end else if (code_valid) begin
			codeword <= {codeword[`BCH_N-2:0], code_bit};
		end
	end

	// **************************************************
	// Completion and verdict
	// **************************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			done  <= 1'b0;
			valid <= 1'b0;
		end else if (start) begin
			done  <= 1'b0;
			valid <= 1'b0;
		end else if (code_last) begin
			// Remainder is final in the last bit cycle.
			done  <= 1'b1;
			valid <= remainder_zero;
		end
	end

endmodule

/* project.f */
+incdir+logic
+incdir+sim
logic/bch_pkg.sv
logic/bch_wb_regs.sv
logic/bch_bit_sequencer.sv
logic/bch_lfsr_divider.sv
logic/bch_word_collector.sv
logic/bch_codec_top.sv
sim/bch_tb.sv

/* sim/bch_wb_host.svh */
`ifndef BCH_WB_HOST_SVH
`define BCH_WB_HOST_SVH

// **************************************************
// Wishbone host side
// **************************************************

// Negedge samples allowed before an ack must show.
localparam int ACK_LIMIT = 16;
// STATUS reads allowed before done must show.
localparam int DONE_LIMIT = 64;

// One classic cycle, driven and sampled on the falling edge.
task automatic bus_cycle(input logic we, input logic [1:0] adr,
		input logic [15:0] wdata, output logic [15:0] rdata);
	int guard;
	@(negedge clk);
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = we;
	wb_adr   = adr;
	wb_wdata = wdata;
	guard    = 0;
	do begin
		@(negedge clk);
		guard++;
	end while (!wb_ack && guard < ACK_LIMIT);
	if (!wb_ack) begin
		abort_run("the slave never acknowledged a bus cycle");
	end else begin
		rdata  = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	end
endtask

task automatic write_reg(input logic [1:0] adr, input logic [15:0] data);
	logic [15:0] unused;
	bus_cycle(1'b1, adr, data, unused);
endtask

task automatic read_reg(input logic [1:0] adr, output logic [15:0] data);
	bus_cycle(1'b0, adr, 16'h0000, data);
endtask

// Polls STATUS until done is set.
task automatic wait_done();
	logic [15:0] status;
	int polls;
	polls = 0;
	read_reg(`BCH_ADDR_STATUS, status);
	while (!status[1] && polls < DONE_LIMIT) begin
		polls++;
		read_reg(`BCH_ADDR_STATUS, status);
	end
	if (!status[1]) begin
		abort_run("done never rose within the poll limit");
	end
endtask

// Long division of msg * x^10 by the full generator 0x537.
function automatic logic [9:0] expected_parity(input logic [4:0] msg);
	logic [14:0] rem;
	int i;
	rem = {msg, 10'b0};
	for (i = 14; i >= 10; i--) begin
		if (rem[i]) begin
			rem = rem ^ (15'h0537 << (i - 10));
		end
	end
	return rem[9:0];
endfunction

`endif

/* sim/bch_tb.sv */
`timescale 1ns/1ps

`include "bch_config.svh"

module bch_tb;

	import bch_pkg::*;

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [15:0] wb_wdata;
	logic [15:0] wb_rdata;
	logic wb_ack;

	int check_count = 0;
	int error_count = 0;
	int test_count = 0;
	int checks_at_start;
	int errors_at_start;
	integer seed = 7548;
	logic [14:0] codes [32];

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$finish;
	endtask

	`include "bch_wb_host.svh"

	bch_codec_top UUT (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_wdata(wb_wdata),
		.wb_rdata(wb_rdata), .wb_ack(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// **************************************************
	// Protocol and sequencing checks
	// **************************************************
	ack_one_cycle: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
		else begin
			error_count++;
			$display("ack stayed high for more than one cycle");
		end

	ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else begin
			error_count++;
			$display("ack came without a strobe in the previous cycle");
		end

	busy_after_done: assert property (@(posedge clk) disable iff (reset)
		$fell(UUT.busy) |-> UUT.done)
		else begin
			error_count++;
			$display("busy fell before done was set");
		end

	// Busy rises only as the FSM enters the feed phase.
	busy_enters_feed: assert property (@(posedge clk) disable iff (reset)
		$rose(UUT.busy) |-> UUT.u_seq.state == SEQ_FEED)
		else begin
			error_count++;
			$display("busy rose while the sequencer was not feeding");
		end

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic begin_test();
		checks_at_start = check_count;
		errors_at_start = error_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %s: %0d checks, %0d errors", name,
			check_count - checks_at_start, error_count - errors_at_start);
	endtask

	task automatic run_op(input bch_op_t op, input logic [14:0] word);
		write_reg(`BCH_ADDR_DATA, {1'b0, word});
		write_reg(`BCH_ADDR_CTRL, {14'b0, op, 1'b1});
		wait_done();
	endtask

	// **************************************************
	// Stimulus
	// **************************************************
	initial begin
		logic [15:0] data;
		logic [14:0] mask;
		logic [14:0] word;
		int m;
		int n;
		int t;
		int idx;
		int pos;

		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 2'd0;
		wb_wdata = 16'h0000;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		begin_test();
		for (m = 0; m < 4; m++) begin
			read_reg(m[1:0], data);
			check_value($sformatf("reset_state reg %0d", m), 16'h0000, data);
		end
		end_test("reset_state");

		// Expected codewords come from the reference division.
		begin_test();
		for (m = 0; m < 32; m++) begin
			codes[m] = {m[4:0], expected_parity(m[4:0])};
			run_op(OP_ENCODE, {10'b0, m[4:0]});
			read_reg(`BCH_ADDR_CODE, data);
			check_value($sformatf("encode msg %h", m[4:0]), {1'b0, codes[m]}, data);
		end
		end_test("encode_all");

		begin_test();
		for (m = 0; m < 32; m++) begin
			run_op(OP_CHECK, codes[m]);
			read_reg(`BCH_ADDR_STATUS, data);
			check_value($sformatf("check_valid word %h", codes[m]), 16'h0001,
				{15'b0, data[2]});
		end
		end_test("check_valid");

		// Minimum distance 7, so up to 6 flips never land on a codeword.
		begin_test();
		for (n = 1; n <= 6; n++) begin
			for (t = 0; t < 8; t++) begin
				idx  = $unsigned($random(seed)) % 32;
				mask = '0;
				while ($countones(mask) < n) begin
					pos = $unsigned($random(seed)) % 15;
					mask[pos] = 1'b1;
				end
				word = codes[idx] ^ mask;
				run_op(OP_CHECK, word);
				read_reg(`BCH_ADDR_STATUS, data);
				check_value($sformatf("check_errors %0d flips word %h", n, word), 16'h0000,
					{15'b0, data[2]});
			end
		end
		end_test("check_errors");

		begin_test();
		write_reg(`BCH_ADDR_DATA, 16'h0013);
		write_reg(`BCH_ADDR_CTRL, {14'b0, OP_ENCODE, 1'b1});
		read_reg(`BCH_ADDR_STATUS, data);
		check_value("busy_start busy bit", 16'h0001, {15'b0, data[0]});
		check_value("busy_start unused bits while busy", 16'h0000, {3'b0, data[15:3]});
		// Second start with the other operation must be dropped.
		write_reg(`BCH_ADDR_CTRL, {14'b0, OP_CHECK, 1'b1});
		wait_done();
		read_reg(`BCH_ADDR_CODE, data);
		check_value("busy_start codeword", {1'b0, codes[5'h13]}, data);
		read_reg(`BCH_ADDR_STATUS, data);
		check_value("busy_start unused bits when done", 16'h0000, {3'b0, data[15:3]});
		end_test("busy_start");

		$display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
